/* digital_clock.f */
src/clock_pkg.sv
src/tick_gen.sv
src/button_debounce.sv
src/mode_control.sv
src/time_counter.sv
src/alarm_unit.sv
src/display_driver.sv
src/digital_clock_top.sv
tests/digital_clock_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module digital_clock_tb -f digital_clock.f > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }
./obj_dir/Vdigital_clock_tb > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation finished clean"; exit 0; }

/* tests/digital_clock_tb.sv */
`timescale 1ns/1ps

module digital_clock_tb import clock_pkg::*; ();

    localparam int TPS          = 40;                       // clk cycles per second
    localparam int DEB          = 4;                        // debounce length in clk cycles
    localparam int SCAN         = 2;                        // clk cycles per lit digit
    localparam int HOLD         = 10;                       // stable cycles after a bounce burst
    localparam int SEC_TIMEOUT  = 2 * TPS;
    localparam int SCAN_TIMEOUT = 4 * DIGITS * SCAN;

    localparam int BTN_MODE = 0;
    localparam int BTN_SEC  = 1;
    localparam int BTN_MIN  = 2;
    localparam int BTN_HOUR = 3;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              enable;
    logic              mode_btn;
    logic              set_sec_btn;
    logic              set_min_btn;
    logic              set_hour_btn;
    logic              show_mode;
    logic [SEG_W-1:0]  seg;
    logic [DIGITS-1:0] digit_sel;
    logic              sec_led;
    logic              alarm_led;

    // reference state kept by the testbench
    int                m_hour;
    int                m_min;
    int                m_sec;
    int                a_hour;
    int                a_min;
    int                a_sec;
    logic [MODE_W-1:0] m_mode;
    logic [31:0]       lfsr_state;

    digital_clock_top #(
        .ticks_per_sec   (TPS),
        .debounce_cycles (DEB),
        .scan_cycles     (SCAN)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .mode_btn     (mode_btn),
        .set_sec_btn  (set_sec_btn),
        .set_min_btn  (set_min_btn),
        .set_hour_btn (set_hour_btn),
        .show_mode    (show_mode),
        .seg          (seg),
        .digit_sel    (digit_sel),
        .sec_led      (sec_led),
        .alarm_led    (alarm_led)
    );

    always #50 clk = ~clk;                                  // 100 ns period

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // taps 32,22,2,1
    endfunction

    function automatic int wrap_inc(input int v, input int last);
        return (v == last) ? 0 : v + 1;
    endfunction

    // decimal digit the display should show at position pos, 3 leftmost
    function automatic logic [BCD_W-1:0] model_digit(input logic [1:0] pos);
        int h;
        int m;
        int s;
        int hi;
        int lo;
        h  = (m_mode == MODE_SET_ALARM) ? a_hour : m_hour;  // alarm shown while setting it
        m  = (m_mode == MODE_SET_ALARM) ? a_min : m_min;
        s  = (m_mode == MODE_SET_ALARM) ? a_sec : m_sec;
        hi = show_mode ? m : h;
        lo = show_mode ? s : m;
        case (pos)
            2'd3:    return BCD_W'(hi / 10);
            2'd2:    return BCD_W'(hi % 10);
            2'd1:    return BCD_W'(lo / 10);
            default: return BCD_W'(lo % 10);
        endcase
    endfunction

    task automatic model_tick();
        m_sec = wrap_inc(m_sec, int'(SEC_MAX));
        if (m_sec == 0)
        begin
            m_min = wrap_inc(m_min, int'(MIN_MAX));         // carry into minutes
            if (m_min == 0)
                m_hour = wrap_inc(m_hour, int'(HOUR_MAX));  // and into hours
        end
    endtask

    task automatic model_press(input int which);
        if (which == BTN_MODE)
        begin
            if (m_mode == MODE_RUN)
                m_mode = MODE_SET_TIME;
            else if (m_mode == MODE_SET_TIME)
                m_mode = MODE_SET_ALARM;
            else
                m_mode = MODE_RUN;
        end
        else if (m_mode == MODE_SET_TIME)
        begin
            case (which)                                    // one field, no carry
                BTN_SEC: m_sec  = wrap_inc(m_sec, int'(SEC_MAX));
                BTN_MIN: m_min  = wrap_inc(m_min, int'(MIN_MAX));
                default: m_hour = wrap_inc(m_hour, int'(HOUR_MAX));
            endcase
        end
        else if (m_mode == MODE_SET_ALARM)
        begin
            case (which)
                BTN_SEC: a_sec  = wrap_inc(a_sec, int'(SEC_MAX));
                BTN_MIN: a_min  = wrap_inc(a_min, int'(MIN_MAX));
                default: a_hour = wrap_inc(a_hour, int'(HOUR_MAX));
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // error handling and compares
    //////////////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_seg(input string name, input logic [SEG_W-1:0] expected,
                             input logic [SEG_W-1:0] actual);
        if (actual !== expected)
            stop_on_error($sformatf("Error at %0d ns: %s expected %h, got %h",
                                    $time, name, expected, actual));
    endtask

    task automatic check_digit_sel(input string name, input logic [DIGITS-1:0] expected,
                                   input logic [DIGITS-1:0] actual);
        if (actual !== expected)
            stop_on_error($sformatf("Error at %0d ns: %s expected %b, got %b",
                                    $time, name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            stop_on_error($sformatf("Error at %0d ns: %s expected %b, got %b",
                                    $time, name, expected, actual));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////
    task automatic next_drive_point();
        @(posedge clk);
        #1;                                                 // drive just after the edge
    endtask

    task automatic random_bit(output logic b);
        b          = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);                 // one step per bit taken
    endtask

    task automatic drive_button(input int which, input logic level);
        next_drive_point();
        case (which)
            BTN_MODE: mode_btn     = level;
            BTN_SEC:  set_sec_btn  = level;
            BTN_MIN:  set_min_btn  = level;
            default:  set_hour_btn = level;
        endcase
    endtask

    // bouncy press and release, bursts stay shorter than the debounce length
    task automatic press_button(input int which);
        logic b;
        int   i;
        for (i = 0; i < DEB - 1; i++)
        begin
            random_bit(b);
            drive_button(which, b);
        end
        repeat (HOLD) drive_button(which, 1'b1);
        for (i = 0; i < DEB - 1; i++)
        begin
            random_bit(b);
            drive_button(which, b);
        end
        repeat (HOLD) drive_button(which, 1'b0);
        model_press(which);
    endtask

    // press until a field reaches target, stepping with wrap
    task automatic step_to(input int which, input int cur, input int target, input int span);
        int presses;
        presses = (target - cur + span) % span;
        repeat (presses) press_button(which);
    endtask

    task automatic set_show(input logic value);
        next_drive_point();
        show_mode = value;
    endtask

    // sec_led rises on the clk where a counted second lands
    task automatic wait_second();
        logic prev;
        logic done;
        int   n;
        prev = sec_led;
        done = 1'b0;
        n    = 0;
        while (!done && n < SEC_TIMEOUT)
        begin
            @(negedge clk);
            done = !prev && sec_led;
            prev = sec_led;
            n++;
        end
        if (!done)
            stop_on_error("timeout: sec_led showed no new second");
    endtask

    task automatic run_seconds(input int count);
        next_drive_point();
        enable = 1'b1;
        repeat (count)
        begin
            wait_second();
            if (m_mode == MODE_RUN)
                model_tick();                               // counter frozen in set modes
        end
        next_drive_point();
        enable = 1'b0;
    endtask

    // scan all four digits and compare each pattern with the model
    task automatic read_display();
        logic [1:0]        pos;
        logic [DIGITS-1:0] want;
        int                k;
        int                n;
        repeat (2) @(negedge clk);                          // let new inputs reach seg
        for (k = 0; k < DIGITS; k++)
        begin
            pos  = 2'(3 - k);
            want = ~(DIGITS'(1) << pos);
            n    = 0;
            while (digit_sel !== want && n < SCAN_TIMEOUT)
            begin
                @(negedge clk);
                n++;
            end
            if (digit_sel !== want)
                stop_on_error($sformatf("timeout: digit %0d was never selected", pos));
            check_seg("seg", SEG_TABLE[model_digit(pos)], seg);
        end
    endtask

    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_digit_sel("digit_sel", 4'b1110, digit_sel);   // digit 0 lit in reset
        check_bit("alarm_led", 1'b0, alarm_led);
        next_drive_point();
        rst_n = 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_paused_after_reset();
        @(negedge clk);
        check_bit("alarm_led", 1'b0, alarm_led);
        set_show(1'b0);
        read_display();                                     // 00:00
        repeat (3 * TPS)
        begin
            @(negedge clk);
            check_bit("sec_led", 1'b1, sec_led);            // steady while paused
        end
        set_show(1'b1);
        read_display();                                     // seconds still 00
    endtask

    task automatic test_minute_carry();
        run_seconds(65);
        set_show(1'b1);
        read_display();                                     // mm:ss 01:05
        set_show(1'b0);
        read_display();
    endtask

    task automatic test_set_time();
        press_button(BTN_MODE);                             // into set-time
        set_show(1'b1);
        repeat (3) press_button(BTN_SEC);
        read_display();
        repeat (2) press_button(BTN_MIN);
        read_display();
        set_show(1'b0);
        repeat (24) press_button(BTN_HOUR);                 // full wrap, back to start
        read_display();
        run_seconds(2);                                     // enable high, clock held
        set_show(1'b1);
        read_display();
    endtask

    task automatic test_set_alarm();
        press_button(BTN_MODE);                             // into set-alarm
        set_show(1'b0);
        read_display();                                     // 12:00 after reset
        press_button(BTN_HOUR);
        press_button(BTN_MIN);
        press_button(BTN_SEC);
        read_display();
        set_show(1'b1);
        read_display();
        press_button(BTN_MODE);                             // back to run, time shown
        read_display();
        set_show(1'b0);
        read_display();
    endtask

    task automatic test_alarm_match();
        int target;
        int i;
        target = (m_hour * 3600 + m_min * 60 + m_sec + 3) % 86400;
        press_button(BTN_MODE);
        press_button(BTN_MODE);                             // set-alarm
        step_to(BTN_HOUR, a_hour, target / 3600, 24);
        step_to(BTN_MIN, a_min, (target / 60) % 60, 60);
        step_to(BTN_SEC, a_sec, target % 60, 60);
        read_display();
        press_button(BTN_MODE);                             // run
        next_drive_point();
        enable = 1'b1;
        for (i = 0; i < 5; i++)
        begin
            wait_second();
            model_tick();
            @(negedge clk);                                 // led is one clk behind
            check_bit("alarm_led", (m_hour == a_hour) && (m_min == a_min) && (m_sec == a_sec),
                      alarm_led);
            repeat (TPS / 2) @(negedge clk);                // middle of the same second
            check_bit("alarm_led", (m_hour == a_hour) && (m_min == a_min) && (m_sec == a_sec),
                      alarm_led);
        end
        next_drive_point();
        enable = 1'b0;
    endtask

    task automatic test_midnight_wrap();
        press_button(BTN_MODE);                             // set-time
        step_to(BTN_HOUR, m_hour, 23, 24);
        step_to(BTN_MIN, m_min, 59, 60);
        step_to(BTN_SEC, m_sec, 58, 60);
        set_show(1'b1);
        read_display();                                     // 59:58
        press_button(BTN_MODE);
        press_button(BTN_MODE);                             // run again
        run_seconds(2);
        set_show(1'b0);
        read_display();                                     // 00:00
        set_show(1'b1);
        read_display();
        run_seconds(1);
        read_display();                                     // mm:ss 00:01
    endtask

    initial
    begin
        rst_n        = 1'b0;
        enable       = 1'b0;
        mode_btn     = 1'b0;
        set_sec_btn  = 1'b0;
        set_min_btn  = 1'b0;
        set_hour_btn = 1'b0;
        show_mode    = 1'b0;
        lfsr_state   = 32'd95524;
        m_hour       = 0;
        m_min        = 0;
        m_sec        = 0;
        a_hour       = int'(ALARM_RESET_HOUR);
        a_min        = 0;
        a_sec        = 0;
        m_mode       = MODE_RUN;

        reset_dut();
        test_paused_after_reset();
        test_minute_carry();
        test_set_time();
        test_set_alarm();
        test_alarm_match();
        test_midnight_wrap();

        $display("Regression passed");
        $finish;
    end

endmodule

/* src/digital_clock_top.sv */
`timescale 1ns/1ps

module digital_clock_top import clock_pkg::*; #(
    parameter int ticks_per_sec   = 50_000_000,             // 50 MHz board clock
    parameter int debounce_cycles = 1_000_000,              // 20 ms stable
    parameter int scan_cycles     = 50_000                  // 1 ms per digit
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enable,                       // run/pause switch
    input  logic              mode_btn,                     // cycles run, set time, set alarm
    input  logic              set_sec_btn,
    input  logic              set_min_btn,
    input  logic              set_hour_btn,
    input  logic              show_mode,                    // 0 hh:mm, 1 mm:ss
    output logic [SEG_W-1:0]  seg,
    output logic [DIGITS-1:0] digit_sel,
    output logic              sec_led,                      // blinks while running
    output logic              alarm_led
);

    logic sec_tick;
    logic sec_phase;
    logic scan_tick;
    logic mode_press;
    logic sec_press;
    logic min_press;
    logic hour_press;
    logic count_en;
    logic time_adj_sec;
    logic time_adj_min;
    logic time_adj_hour;
    logic alarm_adj_sec;
    logic alarm_adj_min;
    logic alarm_adj_hour;
    logic show_alarm;

    logic [TIME_W-1:0] hour;                                // running time
    logic [TIME_W-1:0] min;
    logic [TIME_W-1:0] sec;
    logic [TIME_W-1:0] al_hour;                             // alarm time
    logic [TIME_W-1:0] al_min;
    logic [TIME_W-1:0] al_sec;

    assign sec_led = sec_phase | ~enable;                   // steady on while paused

    tick_gen #(
        .ticks_per_sec (ticks_per_sec),
        .scan_cycles   (scan_cycles)
    ) u_tick_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .sec_tick  (sec_tick),
        .sec_phase (sec_phase),
        .scan_tick (scan_tick)
    );

    button_debounce #(
        .debounce_cycles (debounce_cycles)
    ) u_button_debounce (
        .clk     (clk),
        .rst_n   (rst_n),
        .buttons ({mode_btn, set_sec_btn, set_min_btn, set_hour_btn}),
        .presses ({mode_press, sec_press, min_press, hour_press})
    );

    mode_control u_mode_control (
        .clk            (clk),
        .rst_n          (rst_n),
        .enable         (enable),
        .mode_press     (mode_press),
        .sec_press      (sec_press),
        .min_press      (min_press),
        .hour_press     (hour_press),
        .count_en       (count_en),
        .time_adj_sec   (time_adj_sec),
        .time_adj_min   (time_adj_min),
        .time_adj_hour  (time_adj_hour),
        .alarm_adj_sec  (alarm_adj_sec),
        .alarm_adj_min  (alarm_adj_min),
        .alarm_adj_hour (alarm_adj_hour),
        .show_alarm     (show_alarm)
    );

    time_counter u_time_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .sec_tick      (sec_tick),
        .count_en      (count_en),
        .time_adj_sec  (time_adj_sec),
        .time_adj_min  (time_adj_min),
        .time_adj_hour (time_adj_hour),
        .hour          (hour),
        .min           (min),
        .sec           (sec)
    );

    alarm_unit u_alarm_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .alarm_adj_sec  (alarm_adj_sec),
        .alarm_adj_min  (alarm_adj_min),
        .alarm_adj_hour (alarm_adj_hour),
        .hour           (hour),
        .min            (min),
        .sec            (sec),
        .al_hour        (al_hour),
        .al_min         (al_min),
        .al_sec         (al_sec),
        .alarm_led      (alarm_led)
    );

    display_driver u_display_driver (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_tick  (scan_tick),
        .show_mode  (show_mode),
        .show_alarm (show_alarm),
        .hour       (hour),
        .min        (min),
        .sec        (sec),
        .al_hour    (al_hour),
        .al_min     (al_min),
        .al_sec     (al_sec),
        .seg        (seg),
        .digit_sel  (digit_sel)
    );

endmodule

/* src/display_driver.sv */
`timescale 1ns/1ps

module display_driver import clock_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              scan_tick,                    // move to the next digit
    input  logic              show_mode,                    // 0 hh:mm, 1 mm:ss
    input  logic              show_alarm,                   // 1 shows the alarm time
    input  logic [TIME_W-1:0] hour,
    input  logic [TIME_W-1:0] min,
    input  logic [TIME_W-1:0] sec,
    input  logic [TIME_W-1:0] al_hour,
    input  logic [TIME_W-1:0] al_min,
    input  logic [TIME_W-1:0] al_sec,
    output logic [SEG_W-1:0]  seg,                          // active low segments
    output logic [DIGITS-1:0] digit_sel                     // active low, bit 3 leftmost
);

    logic [TIME_W-1:0] hi_field;                            // left pair of digits
    logic [TIME_W-1:0] lo_field;                            // right pair of digits
    logic [BCD_W-1:0]  digit_val [DIGITS];                  // decimal value per position
    logic [1:0]        idx;                                 // digit being driven
    logic [1:0]        idx_next;
    logic [BCD_W-1:0]  cur_val;

    function automatic logic [BCD_W-1:0] tens_of(input logic [TIME_W-1:0] v);
        return BCD_W'(v / 10);
    endfunction

    function automatic logic [BCD_W-1:0] units_of(input logic [TIME_W-1:0] v);
        return BCD_W'(v % 10);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // source and field pair select
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        if (show_alarm)
        begin
            hi_field = show_mode ? al_min : al_hour;
            lo_field = show_mode ? al_sec : al_min;
        end
        else
        begin
            hi_field = show_mode ? min : hour;
            lo_field = show_mode ? sec : min;
        end
    end

    // bcd split, digit 3 is the left tens digit
    assign digit_val[3] = tens_of(hi_field);
    assign digit_val[2] = units_of(hi_field);
    assign digit_val[1] = tens_of(lo_field);
    assign digit_val[0] = units_of(lo_field);

    //////////////////////////////////////////////////////////////////////
    // scan and segment decode
    //////////////////////////////////////////////////////////////////////
    assign idx_next = scan_tick ? idx + 2'd1 : idx;
    assign cur_val  = digit_val[idx_next];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            idx       <= 2'd0;
            digit_sel <= {{(DIGITS-1){1'b1}}, 1'b0};        // digit 0 lit
        end
        else
        begin
            idx       <= idx_next;
            digit_sel <= ~(DIGITS'(1) << idx_next);         // one-hot low
        end
    end

    // pattern follows the select line in the same clk
    always_ff @(posedge clk)
    begin
        seg <= SEG_TABLE[cur_val];                          // field values keep digits 0..9
    end

endmodule

/* src/alarm_unit.sv */
`timescale 1ns/1ps

module alarm_unit import clock_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alarm_adj_sec,
    input  logic              alarm_adj_min,
    input  logic              alarm_adj_hour,
    input  logic [TIME_W-1:0] hour,                         // running time
    input  logic [TIME_W-1:0] min,
    input  logic [TIME_W-1:0] sec,
    output logic [TIME_W-1:0] al_hour,                      // alarm time
    output logic [TIME_W-1:0] al_min,
    output logic [TIME_W-1:0] al_sec,
    output logic              alarm_led                     // on during the matching second
);

    // alarm time register, stepped like the time fields
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            al_hour <= ALARM_RESET_HOUR;
            al_min  <= '0;
            al_sec  <= '0;
        end
        else
        begin
            if (alarm_adj_sec)
                al_sec <= (al_sec == SEC_MAX) ? '0 : al_sec + 1'b1;
            if (alarm_adj_min)
                al_min <= (al_min == MIN_MAX) ? '0 : al_min + 1'b1;
            if (alarm_adj_hour)
                al_hour <= (al_hour == HOUR_MAX) ? '0 : al_hour + 1'b1;
        end
    end

    // match flag, one clk behind the compare
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            alarm_led <= 1'b0;
        else
            alarm_led <= (hour == al_hour) && (min == al_min) && (sec == al_sec);
    end

endmodule

/* src/time_counter.sv */
`timescale 1ns/1ps

module time_counter import clock_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sec_tick,                     // one-second strobe
    input  logic              count_en,                     // run mode and enabled
    input  logic              time_adj_sec,
    input  logic              time_adj_min,
    input  logic              time_adj_hour,
    output logic [TIME_W-1:0] hour,                         // 0..23
    output logic [TIME_W-1:0] min,                          // 0..59
    output logic [TIME_W-1:0] sec                           // 0..59
);

    //////////////////////////////////////////////////////////////////////
    // counting with carry, manual steps without carry
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hour <= '0;
            min  <= '0;
            sec  <= '0;
        end
        else if (count_en && sec_tick)
        begin
            if (sec == SEC_MAX)
            begin
                sec <= '0;
                if (min == MIN_MAX)
                begin
                    min  <= '0;
                    hour <= (hour == HOUR_MAX) ? '0 : hour + 1'b1; // midnight wrap
                end
                else
                begin
                    min <= min + 1'b1;
                end
            end
            else
            begin
                sec <= sec + 1'b1;
            end
        end
        else
        begin
            // adjust pulses only arrive in set-time, so no overlap with counting
            if (time_adj_sec)
                sec <= (sec == SEC_MAX) ? '0 : sec + 1'b1;
            if (time_adj_min)
                min <= (min == MIN_MAX) ? '0 : min + 1'b1;
            if (time_adj_hour)
                hour <= (hour == HOUR_MAX) ? '0 : hour + 1'b1;
        end
    end

endmodule

/* src/mode_control.sv */
`timescale 1ns/1ps

module mode_control import clock_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,                                    // run/pause switch
    input  logic mode_press,
    input  logic sec_press,
    input  logic min_press,
    input  logic hour_press,
    output logic count_en,                                  // time may advance
    output logic time_adj_sec,
    output logic time_adj_min,
    output logic time_adj_hour,
    output logic alarm_adj_sec,
    output logic alarm_adj_min,
    output logic alarm_adj_hour,
    output logic show_alarm                                 // display the alarm fields
);

    logic [MODE_W-1:0] mode;
    logic              in_set_time;
    logic              in_set_alarm;

    // run -> set time -> set alarm -> run
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            mode <= MODE_RUN;
        else if (mode_press)
        begin
            case (mode)
                MODE_RUN:      mode <= MODE_SET_TIME;
                MODE_SET_TIME: mode <= MODE_SET_ALARM;
                default:       mode <= MODE_RUN;            // also leaves the unused code
            endcase
        end
    end

    assign in_set_time  = (mode == MODE_SET_TIME);
    assign in_set_alarm = (mode == MODE_SET_ALARM);

    assign count_en       = enable && (mode == MODE_RUN);   // clock stops while setting
    assign time_adj_sec   = sec_press && in_set_time;
    assign time_adj_min   = min_press && in_set_time;
    assign time_adj_hour  = hour_press && in_set_time;
    assign alarm_adj_sec  = sec_press && in_set_alarm;
    assign alarm_adj_min  = min_press && in_set_alarm;
    assign alarm_adj_hour = hour_press && in_set_alarm;
    assign show_alarm     = in_set_alarm;

endmodule

/* src/button_debounce.sv */
`timescale 1ns/1ps

module button_debounce #(
    parameter int debounce_cycles = 1_000_000               // stable samples before accept
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] buttons,                             // raw {mode, sec, min, hour}
    output logic [3:0] presses                              // one-clk pulse per press
);

    localparam int CNT_W = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(debounce_cycles - 1);

    logic [3:0]       sync_a;                               // first synchronizer stage
    logic [3:0]       sync_b;                               // second stage, safe to use
    logic [3:0]       level;                                // accepted button level
    logic [CNT_W-1:0] stable_cnt [4];                       // samples differing from level

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync_a  <= '0;
            sync_b  <= '0;
            level   <= '0;
            presses <= '0;
            for (int i = 0; i < 4; i++)
            begin
                stable_cnt[i] <= '0;
            end
        end
        else
        begin
            sync_a <= buttons;
            sync_b <= sync_a;
            for (int i = 0; i < 4; i++)
            begin
                presses[i] <= 1'b0;                         // default, pulse lasts one clk
                if (sync_b[i] == level[i])
                begin
                    stable_cnt[i] <= '0;                    // bounce back, start over
                end
                else if (stable_cnt[i] == CNT_LAST)
                begin
                    stable_cnt[i] <= '0;
                    level[i]      <= sync_b[i];             // new level accepted
                    presses[i]    <= sync_b[i];             // only the rising change counts
                end
                else
                begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

/* src/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
    parameter int ticks_per_sec = 50_000_000,               // clk cycles in one second
    parameter int scan_cycles   = 50_000                    // clk cycles per lit digit
) (
    input  logic clk,
    input  logic rst_n,
    output logic sec_tick,                                  // one clk every second
    output logic sec_phase,                                 // high in first half second
    output logic scan_tick                                  // one clk per digit slot
);

    localparam int SEC_W  = (ticks_per_sec > 1) ? $clog2(ticks_per_sec) : 1;
    localparam int SCAN_W = (scan_cycles > 1) ? $clog2(scan_cycles) : 1;
    localparam logic [SEC_W-1:0]  SEC_LAST  = SEC_W'(ticks_per_sec - 1);
    localparam logic [SEC_W-1:0]  SEC_HALF  = SEC_W'(ticks_per_sec / 2);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(scan_cycles - 1);

    logic [SEC_W-1:0]  sec_cnt;                             // position inside the second
    logic [SCAN_W-1:0] scan_cnt;                            // position inside a digit slot

    // second strobe and blink phase
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sec_cnt   <= '0;
            sec_tick  <= 1'b0;
            sec_phase <= 1'b0;
        end
        else
        begin
            sec_cnt   <= (sec_cnt == SEC_LAST) ? '0 : sec_cnt + 1'b1;
            sec_tick  <= (sec_cnt == SEC_LAST);             // strobe lines up with wrap
            sec_phase <= (sec_cnt < SEC_HALF);
        end
    end

    // digit scan strobe
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            scan_cnt  <= '0;
            scan_tick <= 1'b0;
        end
        else
        begin
            scan_cnt  <= (scan_cnt == SCAN_LAST) ? '0 : scan_cnt + 1'b1;
            scan_tick <= (scan_cnt == SCAN_LAST);
        end
    end

endmodule

/* src/clock_pkg.sv */
package clock_pkg;

    //////////////////////////////////////////////////////////////////////
    // field and bus widths
    //////////////////////////////////////////////////////////////////////
    localparam int TIME_W = 6;                              // one hh, mm or ss field
    localparam int BCD_W  = 4;                              // one decimal digit
    localparam int SEG_W  = 8;                              // dp,g,f,e,d,c,b,a
    localparam int DIGITS = 4;                              // seven-segment digits on the board
    localparam int MODE_W = 2;

    // mode codes, stepped by the mode button in this order
    localparam logic [MODE_W-1:0] MODE_RUN       = 2'd0;    // normal timekeeping
    localparam logic [MODE_W-1:0] MODE_SET_TIME  = 2'd1;    // buttons step the time
    localparam logic [MODE_W-1:0] MODE_SET_ALARM = 2'd2;    // buttons step the alarm

    // last value before each field wraps to zero
    localparam logic [TIME_W-1:0] SEC_MAX  = 6'd59;
    localparam logic [TIME_W-1:0] MIN_MAX  = 6'd59;
    localparam logic [TIME_W-1:0] HOUR_MAX = 6'd23;

    localparam logic [TIME_W-1:0] ALARM_RESET_HOUR = 6'd12; // alarm comes up at 12:00:00

    //////////////////////////////////////////////////////////////////////
    // segment patterns, active low, dp held off
    //////////////////////////////////////////////////////////////////////
    localparam logic [SEG_W-1:0] SEG_TABLE [10] = '{
        8'hC0,                                              // 0
        8'hF9,                                              // 1
        8'hA4,                                              // 2
        8'hB0,                                              // 3
        8'h99,                                              // 4
        8'h92,                                              // 5
        8'h82,                                              // 6
        8'hF8,                                              // 7
        8'h80,                                              // 8
        8'h90                                               // 9
    };

endpackage
